// ==== src/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

	localparam int unsigned SLOT_COUNT = 10; // sprites kept per line.
	localparam int unsigned OAM_COUNT = 40;
	localparam int unsigned IDX_W = 6;
	localparam int unsigned ROW_W = 4; // tall objects have 16 rows.
	localparam int unsigned SLOT_W = 4;
	localparam int unsigned Y_OFFSET = 16; // top line is y minus this.

	// one oam entry as it comes off the scan.
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] x;
	} oam_entry_t;

	typedef struct packed {
		logic             valid;
		logic [IDX_W-1:0] idx;
		logic [ROW_W-1:0] row;
		logic [7:0]       x;
	} sprite_slot_t;

	// handed to the tile fetch.
	typedef struct packed {
		logic [IDX_W-1:0] idx;
		logic [ROW_W-1:0] row;
	} sprite_fetch_t;

endpackage

`default_nettype wire

// ==== src/oam_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module oam_scanner (
	input  logic                     xupy_i,
	input  logic                     arst_n_i,
	input  logic                     scan_start_i,
	input  logic [7:0]               line_i,
	input  logic                     obj_tall_i,
	input  logic                     oam_valid_i,
	input  sprite_pkg::oam_entry_t   oam_entry_i,
	output logic                     wr_o,
	output sprite_pkg::sprite_slot_t wr_slot_o,
	output logic                     line_clear_o
);

	logic [sprite_pkg::IDX_W-1:0] idx_q;
	logic                         idx_done;
	logic [8:0]                   diff;
	logic [8:0]                   height;
	logic                         visible;
	logic                         wr_q;
	logic                         line_clear_q;
	sprite_pkg::sprite_slot_t     slot_d;
	sprite_pkg::sprite_slot_t     slot_q;

	// all entries of this line seen.
	assign idx_done = (idx_q == sprite_pkg::IDX_W'(sprite_pkg::OAM_COUNT));

	// Row of the object that sits on this line. An object below the line
	// gives a negative difference, which wraps far above any height.
	assign diff = {1'b0, line_i} + 9'(sprite_pkg::Y_OFFSET) - {1'b0, oam_entry_i.y};

	assign height = obj_tall_i ? 9'd16 : 9'd8; // 8x16 or 8x8.

	assign visible = oam_valid_i && !idx_done && (diff < height);

	always_comb begin
		slot_d.valid = 1'b1;
		slot_d.idx = idx_q;
		slot_d.row = diff[sprite_pkg::ROW_W-1:0];
		slot_d.x = oam_entry_i.x;
	end

	// oam index follows the stream position.
	always_ff @(posedge xupy_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			idx_q <= '0;
		end else if (scan_start_i) begin
			idx_q <= '0;
		end else if (oam_valid_i && !idx_done) begin
			idx_q <= idx_q + 1'b1;
		end
	end

	always_ff @(posedge xupy_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_q <= 1'b0;
			line_clear_q <= 1'b0;
		end else begin
			wr_q <= visible;
			line_clear_q <= scan_start_i; // lines up with the write stage.
		end
	end

	always_ff @(posedge xupy_i) begin
		if (visible) begin
			slot_q <= slot_d;
		end
	end

	assign wr_o = wr_q;
	assign wr_slot_o = slot_q;
	assign line_clear_o = line_clear_q;

endmodule

`default_nettype wire

// ==== src/sprite_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_store (
	input  logic                                                 xupy_i,
	input  logic                                                 arst_n_i,
	input  logic                                                 line_clear_i,
	input  logic                                                 wr_i,
	input  sprite_pkg::sprite_slot_t                             wr_slot_i,
	input  logic                                                 clear_i,
	input  logic [sprite_pkg::SLOT_W-1:0]                        clear_slot_i,
	output sprite_pkg::sprite_slot_t [sprite_pkg::SLOT_COUNT-1:0] slots_o,
	output logic [sprite_pkg::SLOT_W-1:0]                        slot_count_o
);

	logic [sprite_pkg::SLOT_W-1:0]                        cnt_q;
	logic                                                 full;
	logic                                                 load;
	logic [sprite_pkg::SLOT_COUNT-1:0]                    valid_q;
	sprite_pkg::sprite_slot_t [sprite_pkg::SLOT_COUNT-1:0] data_q;

	assign full = (cnt_q == sprite_pkg::SLOT_W'(sprite_pkg::SLOT_COUNT));

	// extra sprites on a full line are dropped.
	assign load = wr_i && !full && !line_clear_i;

	// The fill counter picks the next slot to load, one slot per sprite.
	always_ff @(posedge xupy_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (line_clear_i) begin
			cnt_q <= '0;
		end else if (load) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge xupy_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else begin
			for (int i = 0; i < sprite_pkg::SLOT_COUNT; i++) begin
				if (line_clear_i) begin
					valid_q[i] <= 1'b0;
				end else begin
					// matcher frees a slot once it is fetched.
					if (clear_i && clear_slot_i == sprite_pkg::SLOT_W'(i)) begin
						valid_q[i] <= 1'b0;
					end
					if (load && cnt_q == sprite_pkg::SLOT_W'(i)) begin
						valid_q[i] <= wr_slot_i.valid;
					end
				end
			end
		end
	end

	always_ff @(posedge xupy_i) begin
		for (int i = 0; i < sprite_pkg::SLOT_COUNT; i++) begin
			if (load && cnt_q == sprite_pkg::SLOT_W'(i)) begin
				data_q[i] <= wr_slot_i;
			end
		end
	end

	// read side shows every slot at once.
	always_comb begin
		for (int i = 0; i < sprite_pkg::SLOT_COUNT; i++) begin
			slots_o[i] = data_q[i];
			slots_o[i].valid = valid_q[i];
		end
	end

	assign slot_count_o = cnt_q;

endmodule

`default_nettype wire

// ==== src/sprite_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_matcher (
	input  logic                                                 xupy_i,
	input  logic                                                 arst_n_i,
	input  logic                                                 px_valid_i,
	input  logic [7:0]                                           px_x_i,
	input  sprite_pkg::sprite_slot_t [sprite_pkg::SLOT_COUNT-1:0] slots_i,
	output logic                                                 clear_o,
	output logic [sprite_pkg::SLOT_W-1:0]                        clear_slot_o,
	output logic                                                 fetch_o,
	output sprite_pkg::sprite_fetch_t                            fetch_data_o
);

	logic [sprite_pkg::SLOT_COUNT-1:0] hit;
	logic                              any_hit;
	logic [sprite_pkg::SLOT_W-1:0]     sel;
	sprite_pkg::sprite_fetch_t         sel_data;
	logic                              fetch_q;
	sprite_pkg::sprite_fetch_t         fetch_data_q;

	always_comb begin
		for (int i = 0; i < sprite_pkg::SLOT_COUNT; i++) begin
			hit[i] = slots_i[i].valid && (slots_i[i].x == px_x_i);
		end
	end

	assign any_hit = px_valid_i && (|hit);

	// Lowest slot wins. Slots fill in oam order, so this is the lowest index.
	always_comb begin
		sel = '0;
		sel_data = '0;
		for (int i = sprite_pkg::SLOT_COUNT - 1; i >= 0; i--) begin
			if (hit[i]) begin
				sel = sprite_pkg::SLOT_W'(i);
				sel_data.idx = slots_i[i].idx;
				sel_data.row = slots_i[i].row;
			end
		end
	end

	// the store drops the slot on the strobe edge itself.
	assign clear_o = any_hit;
	assign clear_slot_o = sel;

	always_ff @(posedge xupy_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			fetch_q <= 1'b0;
		end else begin
			fetch_q <= any_hit;
		end
	end

	always_ff @(posedge xupy_i) begin
		if (any_hit) begin
			fetch_data_q <= sel_data;
		end
	end

	assign fetch_o = fetch_q;
	assign fetch_data_o = fetch_data_q;

endmodule

`default_nettype wire

// ==== src/sprite_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_unit (
	input  logic                          xupy_i,
	input  logic                          arst_n_i,
	input  logic                          scan_start_i,
	input  logic [7:0]                    line_i,
	input  logic                          obj_tall_i,
	input  logic                          oam_valid_i,
	input  sprite_pkg::oam_entry_t        oam_entry_i,
	input  logic                          px_valid_i,
	input  logic [7:0]                    px_x_i,
	output logic                          fetch_o,
	output sprite_pkg::sprite_fetch_t     fetch_data_o,
	output logic [sprite_pkg::SLOT_W-1:0] slot_count_o
);

	logic                                                 wr;
	sprite_pkg::sprite_slot_t                             wr_slot;
	logic                                                 line_clear;
	logic                                                 clear;
	logic [sprite_pkg::SLOT_W-1:0]                        clear_slot;
	sprite_pkg::sprite_slot_t [sprite_pkg::SLOT_COUNT-1:0] slots;

	oam_scanner u_scanner (
		.xupy_i       (xupy_i),
		.arst_n_i     (arst_n_i),
		.scan_start_i (scan_start_i),
		.line_i       (line_i),
		.obj_tall_i   (obj_tall_i),
		.oam_valid_i  (oam_valid_i),
		.oam_entry_i  (oam_entry_i),
		.wr_o         (wr),
		.wr_slot_o    (wr_slot),
		.line_clear_o (line_clear)
	);

	sprite_store u_store (
		.xupy_i       (xupy_i),
		.arst_n_i     (arst_n_i),
		.line_clear_i (line_clear),
		.wr_i         (wr),
		.wr_slot_i    (wr_slot),
		.clear_i      (clear),
		.clear_slot_i (clear_slot),
		.slots_o      (slots),
		.slot_count_o (slot_count_o)
	);

	sprite_matcher u_matcher (
		.xupy_i       (xupy_i),
		.arst_n_i     (arst_n_i),
		.px_valid_i   (px_valid_i),
		.px_x_i       (px_x_i),
		.slots_i      (slots),
		.clear_o      (clear),
		.clear_slot_o (clear_slot),
		.fetch_o      (fetch_o),
		.fetch_data_o (fetch_data_o)
	);

endmodule

`default_nettype wire

// ==== bench/sprite_unit_tb_check.svh ====
`ifndef SPRITE_UNIT_TB_CHECK_SVH
`define SPRITE_UNIT_TB_CHECK_SVH

// 17-bit fibonacci lfsr, taps 17 and 14.
function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_state[16] ^ lfsr_state[13];
	lfsr_state = {lfsr_state[15:0], fb};
	return fb;
endfunction

// one lfsr step per bit taken.
function automatic int rand_bits(input int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		v = (v << 1) | int'(lfsr_step());
	end
	return v;
endfunction

task automatic stop_on_error(input string msg);
	$display("%s", msg);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic check_fetch(
	input string                     name,
	input sprite_pkg::sprite_fetch_t exp,
	input sprite_pkg::sprite_fetch_t act
);
	if (act !== exp) begin
		stop_on_error($sformatf("FAIL %s: expected idx %0d row %0d, actual idx %0d row %0d",
			name, exp.idx, exp.row, act.idx, act.row));
	end
endtask

task automatic check_count(
	input string                         name,
	input logic [sprite_pkg::SLOT_W-1:0] exp,
	input logic [sprite_pkg::SLOT_W-1:0] act
);
	if (act !== exp) begin
		stop_on_error($sformatf("FAIL %s: expected count %0d, actual count %0d",
			name, exp, act));
	end
endtask

`endif

// ==== bench/sprite_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_unit_tb;

	typedef enum int {
		FILL_EDGE,
		FILL_CROWD,
		FILL_NONE,
		FILL_RANDOM
	} fill_t;

	typedef struct {
		string      name;
		logic [7:0] line;
		logic       tall;
		fill_t      fill;
		int         exp_count; // -1 takes the model count.
		logic       sweep;     // 0 leaves sprites behind for the next line.
	} line_test_t;

	logic                          clk;
	logic                          arst_n;
	logic                          scan_start;
	logic [7:0]                    line;
	logic                          obj_tall;
	logic                          oam_valid;
	sprite_pkg::oam_entry_t        oam_entry;
	logic                          px_valid;
	logic [7:0]                    px_x;
	logic                          fetch;
	sprite_pkg::sprite_fetch_t     fetch_data;
	logic [sprite_pkg::SLOT_W-1:0] slot_count;

	logic [16:0]              lfsr_state = 17'd72544;
	line_test_t               tests [9];
	sprite_pkg::oam_entry_t   entries [sprite_pkg::OAM_COUNT];
	sprite_pkg::sprite_slot_t model [$];
	int unsigned              cycles = 0;
	int unsigned              cycle_limit =
		$size(tests) * (50 + 256 + 2 * sprite_pkg::SLOT_COUNT) + 100;

	`include "sprite_unit_tb_check.svh"

	sprite_unit dut_i (
		.xupy_i       (clk),
		.arst_n_i     (arst_n),
		.scan_start_i (scan_start),
		.line_i       (line),
		.obj_tall_i   (obj_tall),
		.oam_valid_i  (oam_valid),
		.oam_entry_i  (oam_entry),
		.px_valid_i   (px_valid),
		.px_x_i       (px_x),
		.fetch_o      (fetch),
		.fetch_data_o (fetch_data),
		.slot_count_o (slot_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		stop_on_error($sformatf("run did not finish within %0d cycles", cycle_limit));
	end

	// d is the wanted row, so y = line + offset - d.
	task automatic fill_entries(input fill_t fill, input logic [7:0] ln);
		int d;
		int edge_d [8] = '{-1, 0, 7, 8, 15, 16, 3, -20};
		for (int i = 0; i < sprite_pkg::OAM_COUNT; i++) begin
			case (fill)
				FILL_EDGE: begin
					d = (i < 8) ? edge_d[i] : 100;
					entries[i].x = 8'(12 * i);
				end
				FILL_CROWD: begin
					d = i % 8;
					entries[i].x = 8'(20 + 10 * (i % 4)); // four columns shared.
				end
				FILL_NONE: begin
					d = 16 + i;
					entries[i].x = 8'(i);
				end
				default: begin
					d = rand_bits(5) - 8;
					entries[i].x = 8'(rand_bits(5));
				end
			endcase
			entries[i].y = 8'(int'(ln) + sprite_pkg::Y_OFFSET - d);
		end
	endtask

	// first ten visible entries in oam order.
	task automatic build_model(input logic [7:0] ln, input logic tall);
		int d;
		int h;
		sprite_pkg::sprite_slot_t s;
		model.delete();
		h = tall ? 16 : 8;
		for (int i = 0; i < sprite_pkg::OAM_COUNT; i++) begin
			d = int'(ln) + int'(sprite_pkg::Y_OFFSET) - int'(entries[i].y);
			if (d >= 0 && d < h && model.size() < sprite_pkg::SLOT_COUNT) begin
				s.valid = 1'b1;
				s.idx = sprite_pkg::IDX_W'(i);
				s.row = sprite_pkg::ROW_W'(d);
				s.x = entries[i].x;
				model.push_back(s);
			end
		end
	endtask

	task automatic scan_line(input line_test_t t);
		int exp_n;
		scan_start = 1'b1;
		line = t.line;
		obj_tall = t.tall;
		@(negedge clk);
		scan_start = 1'b0;
		for (int i = 0; i < sprite_pkg::OAM_COUNT; i++) begin
			if (i == 1) begin
				check_count({t.name, " line clear"}, '0, slot_count); // old line gone.
			end
			oam_valid = 1'b1;
			oam_entry = entries[i];
			@(negedge clk);
		end
		oam_valid = 1'b0;
		repeat (3) @(negedge clk);
		exp_n = (t.exp_count >= 0) ? t.exp_count : model.size();
		check_count({t.name, " after scan"}, sprite_pkg::SLOT_W'(exp_n), slot_count);
	endtask

	// each x is strobed until the model runs dry there and then once more.
	task automatic sweep_pixels(input string name);
		sprite_pkg::sprite_fetch_t exp;
		int hit_k;
		for (int x = 0; x < 256; x++) begin
			do begin
				hit_k = -1;
				for (int k = model.size() - 1; k >= 0; k--) begin
					if (model[k].x == 8'(x)) hit_k = k;
				end
				if (hit_k >= 0) begin
					exp.idx = model[hit_k].idx;
					exp.row = model[hit_k].row;
					model.delete(hit_k);
				end
				px_valid = 1'b1;
				px_x = 8'(x);
				@(negedge clk);
				if (hit_k >= 0) begin
					if (!fetch) begin
						stop_on_error($sformatf("%s: no fetch one cycle after strobe at x=%0d",
							name, x));
					end
					check_fetch($sformatf("%s x=%0d", name, x), exp, fetch_data);
				end else if (fetch) begin
					stop_on_error($sformatf("%s: fetch that was not expected at x=%0d",
						name, x));
				end
			end while (hit_k >= 0);
		end
		px_valid = 1'b0;
	endtask

	initial begin
		arst_n = 1'b0;
		scan_start = 1'b0;
		line = '0;
		obj_tall = 1'b0;
		oam_valid = 1'b0;
		oam_entry = '0;
		px_valid = 1'b0;
		px_x = '0;
		tests = '{
			'{"edge_8x8",    8'd120, 1'b0, FILL_EDGE,    3, 1'b1},
			'{"edge_8x16",   8'd120, 1'b1, FILL_EDGE,    5, 1'b1},
			'{"crowd_keep",  8'd60,  1'b0, FILL_CROWD,  10, 1'b0},
			'{"after_reset", 8'd61,  1'b1, FILL_NONE,    0, 1'b1},
			'{"crowd_tall",  8'd200, 1'b1, FILL_CROWD,  10, 1'b1},
			'{"rand_a",      8'd100, 1'b0, FILL_RANDOM, -1, 1'b1},
			'{"rand_b",      8'd33,  1'b1, FILL_RANDOM, -1, 1'b1},
			'{"rand_keep",   8'd150, 1'b0, FILL_RANDOM, -1, 1'b0},
			'{"rand_c",      8'd151, 1'b0, FILL_RANDOM, -1, 1'b1}
		};
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_count("reset", '0, slot_count);
		if (fetch) begin
			stop_on_error("fetch strobe is high right after reset");
		end
		foreach (tests[r]) begin
			fill_entries(tests[r].fill, tests[r].line);
			build_model(tests[r].line, tests[r].tall);
			scan_line(tests[r]);
			if (tests[r].sweep) begin
				sweep_pixels(tests[r].name);
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+bench
src/sprite_pkg.sv
src/oam_scanner.sv
src/sprite_store.sv
src/sprite_matcher.sv
src/sprite_unit.sv
bench/sprite_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := sprite_unit_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard bench/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
